// File: source/resize_defines.svh
`ifndef RESIZE_DEFINES_SVH
`define RESIZE_DEFINES_SVH

// input frame, 8-bit grey in raster order
`define IMG_WIDTH 640
`define IMG_HEIGHT 480

// one averaging block, 300 pixels
`define BLK_WIDTH 20
`define BLK_HEIGHT 15

// thumbnail is the frame over the block
`define THUMB_WIDTH (`IMG_WIDTH / `BLK_WIDTH)
`define THUMB_HEIGHT (`IMG_HEIGHT / `BLK_HEIGHT)

// 300 * 255 = 76500 fits in 17 bits
`define SUM_WIDTH 17

`endif

// File: source/resize_pkg.sv
`default_nettype none
`include "resize_defines.svh"

package resize_pkg;

  // one grey pixel, also one thumbnail byte
  typedef logic [7:0] pixel_t;

  // running or finished sum of one block
  typedef logic [`SUM_WIDTH-1:0] block_sum_t;

  // frame scan control
  typedef enum logic [1:0] {
    scan_idle,
    scan_run,
    scan_finish
  } scan_state_t;

  // thumbnail output control
  typedef enum logic [1:0] {
    send_idle,
    send_present,
    send_done
  } send_state_t;

endpackage

`default_nettype wire

// File: source/pixel_scan_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "resize_defines.svh"

module pixel_scan_decoder (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  logic               pixel_valid,
  input  resize_pkg::pixel_t pixel_data,
  output logic               pixel_ready,
  output logic               scan_active,
  output logic               pix_valid,
  output resize_pkg::pixel_t pix_data,
  output logic [4:0]         blk_col,
  output logic               blk_last_x,
  output logic               blk_last_y,
  output logic               busy,
  input  logic               done
);

  import resize_pkg::*;

  // wrap values of the nested position counters
  localparam logic [4:0] x_end   = 5'(`BLK_WIDTH - 1);
  localparam logic [4:0] col_end = 5'(`THUMB_WIDTH - 1);
  localparam logic [3:0] y_end   = 4'(`BLK_HEIGHT - 1);
  localparam logic [4:0] row_end = 5'(`THUMB_HEIGHT - 1);

  scan_state_t state;

  // x inside block, block column, y inside block, block row
  logic [4:0] x_cnt;
  logic [4:0] col_cnt;
  logic [3:0] y_cnt;
  logic [4:0] row_cnt;

  logic start_ok;
  logic accept;
  logic at_last_x;
  logic at_last_col;
  logic at_last_y;
  logic at_last_row;
  logic frame_end;

  // start only counts when idle or after the previous frame is fully sent
  assign start_ok = start && ((state == scan_idle) || ((state == scan_finish) && done));

  assign pixel_ready = (state == scan_run);
  assign accept      = pixel_valid && pixel_ready;

  assign at_last_x   = (x_cnt == x_end);
  assign at_last_col = (col_cnt == col_end);
  assign at_last_y   = (y_cnt == y_end);
  assign at_last_row = (row_cnt == row_end);

  // 307200th pixel of the frame
  assign frame_end = accept && at_last_x && at_last_col && at_last_y && at_last_row;

  assign scan_active = (state == scan_run);

  // finish state stays busy until the sender reports done
  assign busy = (state == scan_run) || ((state == scan_finish) && !done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= scan_idle;
    end else begin
      case (state)
        scan_idle: begin
          if (start_ok) begin
            state <= scan_run;
          end
        end
        scan_run: begin
          if (frame_end) begin
            state <= scan_finish;
          end
        end
        scan_finish: begin
          if (start_ok) begin
            state <= scan_run;
          end
        end
        default: begin
          state <= scan_idle;
        end
      endcase
    end
  end

  // nested position counters, x fastest
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_cnt   <= '0;
      col_cnt <= '0;
      y_cnt   <= '0;
      row_cnt <= '0;
    end else if (start_ok) begin
      x_cnt   <= '0;
      col_cnt <= '0;
      y_cnt   <= '0;
      row_cnt <= '0;
    end else if (accept) begin
      if (at_last_x) begin
        x_cnt <= '0;
        if (at_last_col) begin
          col_cnt <= '0;
          if (at_last_y) begin
            y_cnt <= '0;
            if (at_last_row) begin
              row_cnt <= '0;
            end else begin
              row_cnt <= row_cnt + 5'd1;
            end
          end else begin
            y_cnt <= y_cnt + 4'd1;
          end
        end else begin
          col_cnt <= col_cnt + 5'd1;
        end
      end else begin
        x_cnt <= x_cnt + 5'd1;
      end
    end
  end

  // one cycle pipeline stage toward the accumulator
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= accept;
    end
  end

  // flags only meaningful alongside pix_valid
  always_ff @(posedge clk) begin
    if (accept) begin
      pix_data   <= pixel_data;
      blk_col    <= col_cnt;
      blk_last_x <= at_last_x;
      blk_last_y <= at_last_y;
    end
  end

endmodule

`default_nettype wire

// File: source/block_accumulator.sv
`timescale 1ns/1ns
`default_nettype none
`include "resize_defines.svh"

module block_accumulator (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pix_valid,
  input  resize_pkg::pixel_t     pix_data,
  input  logic [4:0]             blk_col,
  input  logic                   blk_last_x,
  input  logic                   blk_last_y,
  input  logic                   scan_active,
  output logic                   sum_valid,
  output resize_pkg::block_sum_t sum_data,
  output logic [9:0]             sum_index
);

  import resize_pkg::*;

  // one partial sum per block column, rows of 32 blocks interleave
  block_sum_t col_sum [`THUMB_WIDTH];

  block_sum_t pix_ext;
  block_sum_t total;
  logic       blk_end;
  logic       scan_active_q;
  logic       new_scan;

  // raster position of the next finished block
  logic [9:0] blk_count;

  assign pix_ext = block_sum_t'(pix_data);
  assign total   = col_sum[blk_col] + pix_ext;

  // last pixel of the last row of a block
  assign blk_end = pix_valid && blk_last_x && blk_last_y;

  // first cycle of a new frame scan
  assign new_scan = scan_active && !scan_active_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `THUMB_WIDTH; i++) begin
        col_sum[i] <= '0;
      end
    end else if (new_scan) begin
      for (int i = 0; i < `THUMB_WIDTH; i++) begin
        col_sum[i] <= '0;
      end
    end else if (pix_valid) begin
      if (blk_end) begin
        // block leaves through sum_data, column restarts
        col_sum[blk_col] <= '0;
      end else begin
        col_sum[blk_col] <= total;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid     <= 1'b0;
      scan_active_q <= 1'b0;
      blk_count     <= '0;
    end else begin
      sum_valid     <= blk_end;
      scan_active_q <= scan_active;
      if (new_scan) begin
        blk_count <= '0;
      end else if (blk_end) begin
        blk_count <= blk_count + 10'd1;
      end
    end
  end

  // blocks finish left to right on the last row, so count is raster order
  always_ff @(posedge clk) begin
    if (blk_end) begin
      sum_data  <= total;
      sum_index <= blk_count;
    end
  end

endmodule

`default_nettype wire

// File: source/block_average_store.sv
`timescale 1ns/1ns
`default_nettype none
`include "resize_defines.svh"

module block_average_store (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sum_valid,
  input  resize_pkg::block_sum_t sum_data,
  input  logic [9:0]             sum_index,
  input  logic [9:0]             rd_index,
  output resize_pkg::pixel_t     rd_data,
  output logic                   frame_stored
);

  import resize_pkg::*;

  localparam int blk_area   = `BLK_WIDTH * `BLK_HEIGHT;
  localparam int thumb_size = `THUMB_WIDTH * `THUMB_HEIGHT;

  // bottom right thumbnail entry
  localparam logic [9:0] last_index = 10'(thumb_size - 1);

  // 32 by 32 thumbnail, row major
  pixel_t thumb_mem [thumb_size];

  pixel_t avg;
  logic   last_write;

  // truncating divide, 76500 / 300 = 255 so the byte never overflows
  assign avg = pixel_t'(sum_data / block_sum_t'(blk_area));

  assign last_write = sum_valid && (sum_index == last_index);

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      thumb_mem[sum_index] <= avg;
    end
  end

  // async read for the sender
  assign rd_data = thumb_mem[rd_index];

  // entry 1023 lands on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_stored <= 1'b0;
    end else begin
      frame_stored <= last_write;
    end
  end

endmodule

`default_nettype wire

// File: source/byte_sender.sv
`timescale 1ns/1ns
`default_nettype none
`include "resize_defines.svh"

module byte_sender (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               frame_stored,
  input  logic               scan_active,
  output logic [9:0]         rd_index,
  input  resize_pkg::pixel_t rd_data,
  output logic               byte_valid,
  output resize_pkg::pixel_t byte_data,
  input  logic               byte_ready,
  output logic               done
);

  import resize_pkg::*;

  localparam logic [9:0] last_index = 10'(`THUMB_WIDTH * `THUMB_HEIGHT - 1);

  send_state_t state;

  // index of the byte currently on byte_data
  logic [9:0] byte_idx;
  logic       xfer;
  logic       load;

  assign xfer = byte_valid && byte_ready;

  // read ahead on a transfer so the next byte follows back to back
  assign rd_index = xfer ? (byte_idx + 10'd1) : byte_idx;

  // fetch first byte, or next one after a transfer
  assign load = ((state == send_idle) && frame_stored) || xfer;

  // drops as soon as the next scan begins
  assign done = (state == send_done) && !scan_active;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= send_idle;
      byte_valid <= 1'b0;
      byte_idx   <= '0;
    end else begin
      case (state)
        send_idle: begin
          if (frame_stored) begin
            byte_valid <= 1'b1;
            state      <= send_present;
          end
        end
        send_present: begin
          if (xfer) begin
            // wraps back to 0 after the last byte
            byte_idx <= byte_idx + 10'd1;
            if (byte_idx == last_index) begin
              byte_valid <= 1'b0;
              state      <= send_done;
            end
          end
        end
        send_done: begin
          if (scan_active) begin
            state <= send_idle;
          end
        end
        default: begin
          state      <= send_idle;
          byte_valid <= 1'b0;
        end
      endcase
    end
  end

  // held steady while the sink stalls
  always_ff @(posedge clk) begin
    if (load) begin
      byte_data <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: source/image_downscaler.sv
`timescale 1ns/1ns
`default_nettype none

module image_downscaler (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  logic               pixel_valid,
  input  resize_pkg::pixel_t pixel_data,
  output logic               pixel_ready,
  output logic               byte_valid,
  output resize_pkg::pixel_t byte_data,
  input  logic               byte_ready,
  output logic               busy,
  output logic               done
);

  import resize_pkg::*;

  // decoder to accumulator
  logic       pix_valid;
  pixel_t     pix_data;
  logic [4:0] blk_col;
  logic       blk_last_x;
  logic       blk_last_y;
  logic       scan_active;

  // accumulator to store
  logic       sum_valid;
  block_sum_t sum_data;
  logic [9:0] sum_index;

  // store and sender
  logic       frame_stored;
  logic [9:0] rd_index;
  pixel_t     rd_data;

  pixel_scan_decoder u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .pixel_valid (pixel_valid),
    .pixel_data  (pixel_data),
    .pixel_ready (pixel_ready),
    .scan_active (scan_active),
    .pix_valid   (pix_valid),
    .pix_data    (pix_data),
    .blk_col     (blk_col),
    .blk_last_x  (blk_last_x),
    .blk_last_y  (blk_last_y),
    .busy        (busy),
    .done        (done)
  );

  block_accumulator u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_valid   (pix_valid),
    .pix_data    (pix_data),
    .blk_col     (blk_col),
    .blk_last_x  (blk_last_x),
    .blk_last_y  (blk_last_y),
    .scan_active (scan_active),
    .sum_valid   (sum_valid),
    .sum_data    (sum_data),
    .sum_index   (sum_index)
  );

  block_average_store u_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .sum_valid    (sum_valid),
    .sum_data     (sum_data),
    .sum_index    (sum_index),
    .rd_index     (rd_index),
    .rd_data      (rd_data),
    .frame_stored (frame_stored)
  );

  byte_sender u_send (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame_stored (frame_stored),
    .scan_active  (scan_active),
    .rd_index     (rd_index),
    .rd_data      (rd_data),
    .byte_valid   (byte_valid),
    .byte_data    (byte_data),
    .byte_ready   (byte_ready),
    .done         (done)
  );

endmodule

`default_nettype wire

// File: testbench/tb_image_downscaler.sv
`timescale 1ns/1ns
`default_nettype none
`include "resize_defines.svh"

module tb_image_downscaler;

  import resize_pkg::*;

  localparam int img_size   = `IMG_WIDTH * `IMG_HEIGHT;
  localparam int thumb_size = `THUMB_WIDTH * `THUMB_HEIGHT;
  localparam int blk_area   = `BLK_WIDTH * `BLK_HEIGHT;
  localparam logic [31:0] lfsr_seed = 32'h22b5e172;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   start;
  logic   pixel_valid;
  pixel_t pixel_data;
  logic   pixel_ready;
  logic   byte_valid;
  pixel_t byte_data;
  logic   byte_ready;
  logic   busy;
  logic   done;

  // current frame and its expected thumbnail
  pixel_t frame_pix [img_size];
  pixel_t exp_bytes [thumb_size];

  logic [31:0] lfsr_state;
  int in_count;
  int out_count;
  int total_bytes;
  int error_count = 0;

  image_downscaler dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .pixel_valid (pixel_valid),
    .pixel_data  (pixel_data),
    .pixel_ready (pixel_ready),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .byte_ready  (byte_ready),
    .busy        (busy),
    .done        (done)
  );

  always #5 clk = ~clk;

  // per frame transfer counts cleared by an accepted start
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_count    <= 0;
      out_count   <= 0;
      total_bytes <= 0;
    end else begin
      if (start && !busy) begin
        in_count  <= 0;
        out_count <= 0;
      end else begin
        if (pixel_valid && pixel_ready) begin
          in_count <= in_count + 1;
        end
        if (byte_valid && byte_ready) begin
          out_count <= out_count + 1;
        end
      end
      if (byte_valid && byte_ready) begin
        total_bytes <= total_bytes + 1;
      end
    end
  end

  task automatic record_error(input string msg);
    error_count++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  // quiet outputs in reset and on the first cycle out of it
  a_reset_quiet: assert property (@(posedge clk)
    (!rst_n || $rose(rst_n)) |-> (!pixel_ready && !byte_valid && !busy && !done))
    else record_error("outputs not low around reset");

  // each byte is the mean of its block in raster order
  a_byte_value: assert property (@(posedge clk) disable iff (!rst_n)
    (byte_valid && byte_ready) |-> (byte_data == exp_bytes[out_count]))
    else record_error($sformatf("byte %0d expected %02h got %02h", $sampled(out_count),
                                exp_bytes[$sampled(out_count)], $sampled(byte_data)));

  a_byte_limit: assert property (@(posedge clk) disable iff (!rst_n)
    (byte_valid && byte_ready) |-> (out_count < thumb_size))
    else record_error($sformatf("extra byte, count %0d", $sampled(out_count)));

  // stalled output stays put
  a_byte_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (byte_valid && !byte_ready) |=> (byte_valid && $stable(byte_data)))
    else record_error("byte_valid or byte_data changed under stall");

  a_done_count: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done) |-> (out_count == thumb_size && !busy))
    else record_error($sformatf("done rose after %0d bytes, expected %0d",
                                $sampled(out_count), thumb_size));

  // input closes after the last pixel of the frame
  a_ready_drop: assert property (@(posedge clk) disable iff (!rst_n)
    (pixel_valid && pixel_ready && in_count == img_size - 1) |=> !pixel_ready)
    else record_error("pixel_ready still high after last pixel");

  a_pixel_limit: assert property (@(posedge clk) disable iff (!rst_n)
    pixel_ready |-> (in_count < img_size))
    else record_error($sformatf("pixel_ready high after %0d pixels", $sampled(in_count)));

  // a stray start neither ends the frame nor reopens the input
  a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
    (start && busy) |=> ((busy || done) && (pixel_ready == (in_count < img_size))))
    else record_error("start during busy disturbed the frame");

  a_done_clear: assert property (@(posedge clk) disable iff (!rst_n)
    (start && done) |=> (busy && !done && pixel_ready))
    else record_error("start after done did not begin a new scan");

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic pixel_t next_byte();
    pixel_t b;
    for (int i = 0; i < 8; i++) begin
      b[i] = next_bit();
    end
    return b;
  endfunction

  // pattern 0 is random and pattern 1 a folded gradient
  function automatic void fill_frame(input int pattern);
    for (int y = 0; y < `IMG_HEIGHT; y++) begin
      for (int x = 0; x < `IMG_WIDTH; x++) begin
        if (pattern == 0) begin
          frame_pix[y * `IMG_WIDTH + x] = next_byte();
        end else begin
          frame_pix[y * `IMG_WIDTH + x] = pixel_t'((x ^ y) + (y >> 3));
        end
      end
    end
  endfunction

  // truncated mean of every block
  function automatic void compute_expected();
    int sum;
    for (int by = 0; by < `THUMB_HEIGHT; by++) begin
      for (int bx = 0; bx < `THUMB_WIDTH; bx++) begin
        sum = 0;
        for (int y = 0; y < `BLK_HEIGHT; y++) begin
          for (int x = 0; x < `BLK_WIDTH; x++) begin
            sum += frame_pix[(by * `BLK_HEIGHT + y) * `IMG_WIDTH + bx * `BLK_WIDTH + x];
          end
        end
        exp_bytes[by * `THUMB_WIDTH + bx] = pixel_t'(sum / blk_area);
      end
    end
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("bytes received %0d, errors %0d", total_bytes, error_count);
    $display("Finished with errors");
    $finish;
  endtask

  // one cycle with inputs changing 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
    byte_ready = next_bit();
  endtask

  task automatic pulse_start();
    start = 1'b1;
    tick();
    start = 1'b0;
  endtask

  task automatic wait_pixel_ready();
    int waited;
    waited = 0;
    while (!pixel_ready) begin
      if (waited == 100) begin
        abort_run("timeout waiting for pixel_ready");
      end
      tick();
      waited++;
    end
  endtask

  // stream one frame with a stray start at pixel 5000
  task automatic stream_frame(input bit with_gaps);
    int  idx;
    int  waited;
    bit  xfer;
    bit  gap_bit;
    idx    = 0;
    waited = 0;
    while (idx < img_size) begin
      pixel_data = frame_pix[idx];
      gap_bit    = with_gaps ? next_bit() : 1'b1;
      if (!pixel_valid) begin
        pixel_valid = gap_bit;
      end
      xfer  = pixel_valid && pixel_ready;
      start = xfer && (idx == 5000);
      tick();
      if (xfer) begin
        idx++;
        waited = 0;
        pixel_valid = !with_gaps;
      end else begin
        waited++;
        if (waited == 100) begin
          abort_run("timeout waiting for pixel accept");
        end
      end
    end
    pixel_valid = 1'b0;
    start       = 1'b0;
  endtask

  task automatic wait_byte_valid();
    int waited;
    waited = 0;
    while (!byte_valid) begin
      if (waited == 100) begin
        abort_run("timeout waiting for byte_valid");
      end
      tick();
      waited++;
    end
  endtask

  // a start while sending must be ignored
  task automatic wait_done();
    int waited;
    waited = 0;
    while (!done) begin
      if (waited == 20000) begin
        abort_run("timeout waiting for done");
      end
      start = (waited == 100);
      tick();
      waited++;
    end
    start = 1'b0;
  endtask

  initial begin
    rst_n       = 1'b0;
    start       = 1'b0;
    pixel_valid = 1'b0;
    pixel_data  = '0;
    byte_ready  = 1'b0;
    lfsr_state  = lfsr_seed;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) tick();

    // first frame of random pixels without gaps
    fill_frame(0);
    compute_expected();
    pulse_start();
    wait_pixel_ready();
    stream_frame(1'b0);
    wait_byte_valid();
    wait_done();
    repeat (5) tick();

    // second frame from done as a gradient with valid gaps
    fill_frame(1);
    compute_expected();
    pulse_start();
    wait_pixel_ready();
    stream_frame(1'b1);
    wait_byte_valid();
    wait_done();
    repeat (5) tick();

    $display("bytes received %0d, errors %0d", total_bytes, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+source
source/resize_pkg.sv
source/pixel_scan_decoder.sv
source/block_accumulator.sv
source/block_average_store.sv
source/byte_sender.sv
source/image_downscaler.sv
testbench/tb_image_downscaler.sv
